// ==== common/tcb_lite_cfg.svh ====
////////////////////////////////////////////////////////////////////////////
// TCB-Lite configuration: bus widths, address map, memory and fifo depths
////////////////////////////////////////////////////////////////////////////

`ifndef TCB_LITE_CFG_SVH
`define TCB_LITE_CFG_SVH

// bus widths
`define TCB_ADR 32
`define TCB_DAT 32
// one enable per byte lane
`define TCB_BEN (`TCB_DAT/8)

// number of subordinates on the demultiplexer
`define TCB_IFN 2

////////////////////////////////////////////////////////////////////////////
// address map
////////////////////////////////////////////////////////////////////////////

// wildcard patterns, x bits are don't care in the match
// memory 0x0000_0000 .. 0x0000_0fff
`define TCB_DAM_MEM 32'b0000_0000_0000_0000_0000_xxxx_xxxx_xxxx
// mailbox 0x0000_1000 .. 0x0000_100f
`define TCB_DAM_MBX 32'b0000_0000_0000_0000_0001_0000_0000_xxxx

////////////////////////////////////////////////////////////////////////////
// subordinate sizes
////////////////////////////////////////////////////////////////////////////

// memory depth in words
`define MEM_DEPTH 256

// mailbox fifo entries, power of two
`define MBX_DEPTH 4

`endif

// ==== common/tcb_lite_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB-Lite shared types: bus operation, mailbox register select
// and subordinate index
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_lite_cfg.svh"

package tcb_lite_pkg;

    ////////////////////////////////////////////////////////////////////////
    // bus operation
    ////////////////////////////////////////////////////////////////////////

    // single bit on the bus, write when high
    typedef enum logic {
        TCB_READ  = 1'b0,
        TCB_WRITE = 1'b1
    } tcb_op_t;

    ////////////////////////////////////////////////////////////////////////
    // mailbox registers
    ////////////////////////////////////////////////////////////////////////

    // decoded from address bit 2
    typedef enum logic {
        MBX_DATA = 1'b0,  // offset 0, fifo push/pop
        MBX_STAT = 1'b1   // offset 4, fill count
    } mbx_reg_t;

    ////////////////////////////////////////////////////////////////////////
    // subordinate index
    ////////////////////////////////////////////////////////////////////////

    // at least one bit, even for a single subordinate
    localparam int unsigned TCB_IFL = (`TCB_IFN > 1) ? $clog2(`TCB_IFN) : 1;

    typedef logic [TCB_IFL-1:0] tcb_sel_t;

endpackage : tcb_lite_pkg

`default_nettype wire

// ==== interconnect/tcb_lite_lib_decoder.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB-Lite address decoder: wildcard region match, binary select,
// unmapped address error
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_lite_cfg.svh"

module tcb_lite_lib_decoder #(
    // number of subordinate regions
    parameter int unsigned IFN = `TCB_IFN
)(
    input  wire logic [`TCB_ADR-1:0]   adr,
    output tcb_lite_pkg::tcb_sel_t     sel,
    output logic                       err
);

    ////////////////////////////////////////////////////////////////////////
    // region table
    ////////////////////////////////////////////////////////////////////////

    // index order is the subordinate order of the demultiplexer
    // sized by IFN so a mismatched map fails at elaboration
    localparam logic [`TCB_ADR-1:0] DAM [IFN] = '{
        `TCB_DAM_MEM,
        `TCB_DAM_MBX
    };

    // one bit per region
    logic [IFN-1:0] mch;

    ////////////////////////////////////////////////////////////////////////
    // match and encode
    ////////////////////////////////////////////////////////////////////////

    // wildcard compare, x bits in the pattern match anything
    for (genvar i = 0; i < IFN; i++) begin : g_match
        assign mch[i] = (adr ==? DAM[i]);
    end

    // one-hot to binary
    // relies on at most one bit set
    function automatic tcb_lite_pkg::tcb_sel_t encode(input logic [IFN-1:0] val);
        tcb_lite_pkg::tcb_sel_t idx;
        idx = '0;
        for (int i = 0; i < IFN; i++) begin
            if (val[i]) begin
                idx |= tcb_lite_pkg::tcb_sel_t'(i);
            end
        end
        return idx;
    endfunction : encode

    assign sel = encode(mch);
    // no region hit
    assign err = ~|mch;

    // overlapping regions would give a wrong encoded select
    always_comb begin
        assert ($onehot0(mch))
            else $error("decoder: address %h hits more than one region", adr);
    end

endmodule : tcb_lite_lib_decoder

`default_nettype wire

// ==== interconnect/tcb_lite_lib_demultiplexer.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB-Lite demultiplexer: request steering by decoder select, one-cycle
// response multiplexer, error response for unmapped addresses
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_lite_cfg.svh"

module tcb_lite_lib_demultiplexer #(
    // number of subordinates
    parameter int unsigned IFN = `TCB_IFN
)(
    input  wire logic                             clk,
    input  wire logic                             arst_n,
    // manager side handshake and response
    input  wire logic                             vld,
    output logic                                  rdy,
    output logic [`TCB_DAT-1:0]                   rdt,
    output logic                                  err,
    // decoder result for the current request
    input  wire tcb_lite_pkg::tcb_sel_t           sel,
    input  wire logic                             dec_err,
    // subordinate side
    output logic [IFN-1:0]                        sub_vld,
    input  wire logic [IFN-1:0]                   sub_rdy,
    input  wire logic [IFN-1:0][`TCB_DAT-1:0]     sub_rdt,
    input  wire logic [IFN-1:0]                   sub_err
);

    // manager side transfer
    logic                   trn;

    // select and decode error of the transfer in the response cycle
    tcb_lite_pkg::tcb_sel_t sel_q;
    logic                   dec_err_q;

    ////////////////////////////////////////////////////////////////////////
    // request path
    ////////////////////////////////////////////////////////////////////////

    // valid reaches only the selected subordinate
    // unmapped requests are kept away from every subordinate
    always_comb begin
        for (int i = 0; i < IFN; i++) begin
            sub_vld[i] = vld & ~dec_err & (sel == tcb_lite_pkg::tcb_sel_t'(i));
        end
    end

    // unmapped requests complete at once, demux answers them itself
    assign rdy = dec_err ? 1'b1 : sub_rdy[sel];

    assign trn = vld & rdy;

    ////////////////////////////////////////////////////////////////////////
    // response path
    ////////////////////////////////////////////////////////////////////////

    // remember the target of each accepted transfer
    // held while idle, response lines are ignored then anyway
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sel_q     <= '0;
            dec_err_q <= 1'b0;
        end else if (trn) begin
            sel_q     <= sel;
            dec_err_q <= dec_err;
        end
    end

    // data from the registered target
    // zero on a decode error, no subordinate was accessed
    assign rdt = dec_err_q ? '0 : sub_rdt[sel_q];

    // decode error overrides the subordinate error
    assign err = dec_err_q | sub_err[sel_q];

    ////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////

    // a request never reaches two subordinates in the same cycle
    a_sub_vld_onehot0 : assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(sub_vld)
    ) else $error("demultiplexer: more than one subordinate valid");

endmodule : tcb_lite_lib_demultiplexer

`default_nettype wire

// ==== rtl/tcb_lite_lib_memory.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB-Lite word memory, byte enable writes, registered read data
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_lite_cfg.svh"

module tcb_lite_lib_memory (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    // request
    input  wire logic                    vld,
    input  wire tcb_lite_pkg::tcb_op_t   op,
    input  wire logic [`TCB_ADR-1:0]     adr,
    input  wire logic [`TCB_BEN-1:0]     ben,
    input  wire logic [`TCB_DAT-1:0]     wdt,
    // response
    output logic                         rdy,
    output logic [`TCB_DAT-1:0]          rdt,
    output logic                         err
);

    // word index width
    localparam int unsigned MAW = $clog2(`MEM_DEPTH);

    logic [`TCB_DAT-1:0] mem [`MEM_DEPTH];
    logic [MAW-1:0]      idx;

    // byte address to word index
    // upper region bits alias onto the array
    assign idx = adr[MAW+1:2];

    ////////////////////////////////////////////////////////////////////////
    // array access
    ////////////////////////////////////////////////////////////////////////

    // write, byte lanes picked by ben
    always_ff @(posedge clk) begin
        if (vld && op == tcb_lite_pkg::TCB_WRITE) begin
            for (int b = 0; b < `TCB_BEN; b++) begin
                if (ben[b]) begin
                    mem[idx][8*b +: 8] <= wdt[8*b +: 8];
                end
            end
        end
    end

    // read, word available the cycle after the transfer
    always_ff @(posedge clk) begin
        if (vld && op == tcb_lite_pkg::TCB_READ) begin
            rdt <= mem[idx];
        end
    end

    // never stalls
    assign rdy = 1'b1;
    // every access succeeds
    assign err = 1'b0;

    // word aligned accesses only
    a_aligned : assert property (
        @(posedge clk) disable iff (!arst_n)
        vld |-> (adr[1:0] == 2'b00)
    ) else $error("memory: misaligned access at %h", adr);

endmodule : tcb_lite_lib_memory

`default_nettype wire

// ==== rtl/tcb_lite_lib_mailbox.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB-Lite mailbox: data register on a small fifo, status register with
// the fill count, write back-pressure when full
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_lite_cfg.svh"

module tcb_lite_lib_mailbox (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    // request
    input  wire logic                    vld,
    input  wire tcb_lite_pkg::tcb_op_t   op,
    input  wire logic [`TCB_ADR-1:0]     adr,
    input  wire logic [`TCB_BEN-1:0]     ben,
    input  wire logic [`TCB_DAT-1:0]     wdt,
    // response
    output logic                         rdy,
    output logic [`TCB_DAT-1:0]          rdt,
    output logic                         err
);

    // pointer width, count needs one more bit
    localparam int unsigned PTW = $clog2(`MBX_DEPTH);

    logic [`TCB_DAT-1:0]    fifo [`MBX_DEPTH];
    logic [PTW-1:0]         wp;
    logic [PTW-1:0]         rp;
    logic [PTW:0]           cnt;

    tcb_lite_pkg::mbx_reg_t reg_sel;
    logic                   full;
    logic                   empty;
    logic                   trn;
    logic                   push;
    logic                   pop;
    logic                   rd_err;

    ////////////////////////////////////////////////////////////////////////
    // access decode
    ////////////////////////////////////////////////////////////////////////

    // offset 0 data, offset 4 status
    assign reg_sel = tcb_lite_pkg::mbx_reg_t'(adr[2]);

    assign full  = (cnt == (PTW+1)'(`MBX_DEPTH));
    assign empty = (cnt == '0);

    // stall only data writes into a full fifo
    // reads and status writes always go through
    assign rdy = ~(op == tcb_lite_pkg::TCB_WRITE &&
                   reg_sel == tcb_lite_pkg::MBX_DATA && full);

    assign trn = vld & rdy;

    // push on data write, partial byte enables still write the whole word
    assign push = trn && op == tcb_lite_pkg::TCB_WRITE && reg_sel == tcb_lite_pkg::MBX_DATA
                  && |ben;
    // pop on data read of a non-empty fifo
    assign pop  = trn && op == tcb_lite_pkg::TCB_READ && reg_sel == tcb_lite_pkg::MBX_DATA
                  && !empty;
    // empty data read, answered with error
    assign rd_err = trn && op == tcb_lite_pkg::TCB_READ &&
                    reg_sel == tcb_lite_pkg::MBX_DATA && empty;

    ////////////////////////////////////////////////////////////////////////
    // fifo
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            fifo[wp] <= wdt;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wp  <= '0;
            rp  <= '0;
            cnt <= '0;
        end else begin
            if (push) begin
                wp <= wp + 1'b1;
            end
            if (pop) begin
                rp <= rp + 1'b1;
            end
            if (push && !pop) begin
                cnt <= cnt + 1'b1;
            end else if (pop && !push) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // response
    ////////////////////////////////////////////////////////////////////////

    // read data, oldest entry or fill count
    always_ff @(posedge clk) begin
        if (trn && op == tcb_lite_pkg::TCB_READ) begin
            if (reg_sel == tcb_lite_pkg::MBX_STAT) begin
                rdt <= `TCB_DAT'(cnt);
            end else begin
                rdt <= empty ? '0 : fifo[rp];
            end
        end
    end

    // error flag refreshed on every transfer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            err <= 1'b0;
        end else if (trn) begin
            err <= rd_err;
        end
    end

    // full fifo must not take a push, count stays bounded and in step
    // with the pointers
    a_no_push_full : assert property (
        @(posedge clk) disable iff (!arst_n)
        full |=> (cnt <= (PTW+1)'(`MBX_DEPTH)) && (cnt[PTW-1:0] == wp - rp)
    ) else $error("mailbox: push into full fifo");

    // empty fifo must not pop, count would wrap below zero
    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (!arst_n)
        empty |=> (cnt <= (PTW+1)'(1)) && (cnt[PTW-1:0] == wp - rp)
    ) else $error("mailbox: pop from empty fifo");

endmodule : tcb_lite_lib_mailbox

`default_nettype wire

// ==== rtl/tcb_lite_subsystem.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB-Lite subsystem: decoder, demultiplexer, memory and mailbox
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_lite_cfg.svh"

module tcb_lite_subsystem (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    // manager request
    input  wire logic                    vld,
    input  wire tcb_lite_pkg::tcb_op_t   op,
    input  wire logic [`TCB_ADR-1:0]     adr,
    input  wire logic [`TCB_BEN-1:0]     ben,
    input  wire logic [`TCB_DAT-1:0]     wdt,
    // manager response
    output logic                         rdy,
    output logic [`TCB_DAT-1:0]          rdt,
    output logic                         err
);

    // decoder result
    tcb_lite_pkg::tcb_sel_t                sel;
    logic                                  dec_err;

    // subordinate bundle, index 0 memory, index 1 mailbox
    logic [`TCB_IFN-1:0]                   sub_vld;
    logic [`TCB_IFN-1:0]                   sub_rdy;
    logic [`TCB_IFN-1:0][`TCB_DAT-1:0]     sub_rdt;
    logic [`TCB_IFN-1:0]                   sub_err;

    ////////////////////////////////////////////////////////////////////////
    // interconnect
    ////////////////////////////////////////////////////////////////////////

    tcb_lite_lib_decoder #(
        .IFN     (`TCB_IFN)
    ) u_decoder (
        .adr     (adr),
        .sel     (sel),
        .err     (dec_err)
    );

    tcb_lite_lib_demultiplexer #(
        .IFN     (`TCB_IFN)
    ) u_demux (
        .clk     (clk),
        .arst_n  (arst_n),
        .vld     (vld),
        .rdy     (rdy),
        .rdt     (rdt),
        .err     (err),
        .sel     (sel),
        .dec_err (dec_err),
        .sub_vld (sub_vld),
        .sub_rdy (sub_rdy),
        .sub_rdt (sub_rdt),
        .sub_err (sub_err)
    );

    ////////////////////////////////////////////////////////////////////////
    // subordinates
    ////////////////////////////////////////////////////////////////////////

    // request fields are shared, only valid is steered
    tcb_lite_lib_memory u_memory (
        .clk     (clk),
        .arst_n  (arst_n),
        .vld     (sub_vld[0]),
        .op      (op),
        .adr     (adr),
        .ben     (ben),
        .wdt     (wdt),
        .rdy     (sub_rdy[0]),
        .rdt     (sub_rdt[0]),
        .err     (sub_err[0])
    );

    tcb_lite_lib_mailbox u_mailbox (
        .clk     (clk),
        .arst_n  (arst_n),
        .vld     (sub_vld[1]),
        .op      (op),
        .adr     (adr),
        .ben     (ben),
        .wdt     (wdt),
        .rdy     (sub_rdy[1]),
        .rdt     (sub_rdt[1]),
        .err     (sub_err[1])
    );

endmodule : tcb_lite_subsystem

`default_nettype wire

// ==== testbench/tcb_lite_subsystem_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the TCB-Lite subsystem: clock and reset, bus tasks,
// reference model and response assertions
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_lite_cfg.svh"

module tcb_lite_subsystem_tb;

    // rough stimulus length in cycles, timeout is four times that
    localparam int STIM_CYCLES    = 500;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES;
    // memory words touched by the tests
    localparam int MEM_WORDS      = 8;

    localparam logic [`TCB_ADR-1:0] MBX_DATA_ADR = 32'h0000_1000;
    localparam logic [`TCB_ADR-1:0] MBX_STAT_ADR = 32'h0000_1004;
    localparam logic [`TCB_ADR-1:0] UNMAPPED_ADR = 32'h0000_2000;
    // just past the mailbox region
    localparam logic [`TCB_ADR-1:0] UNMAPPED_MBX = 32'h0000_1010;

    logic                  clk;
    logic                  arst_n;
    logic                  vld;
    tcb_lite_pkg::tcb_op_t op;
    logic [`TCB_ADR-1:0]   adr;
    logic [`TCB_BEN-1:0]   ben;
    logic [`TCB_DAT-1:0]   wdt;
    logic                  rdy;
    logic [`TCB_DAT-1:0]   rdt;
    logic                  err;

    // expected response, valid in the cycle after a transfer
    logic                  chk_pend;
    logic                  chk_rdt;
    logic [`TCB_DAT-1:0]   exp_rdt;
    logic                  exp_err;
    string                 exp_test;
    // set while a write into a full mailbox must stall
    logic                  hold_stall;
    string                 test_name;

    // model state
    logic [`TCB_DAT-1:0]   mem_model [logic [`TCB_ADR-1:0]];
    logic [`TCB_DAT-1:0]   mbx_model [$];

    int                    trn_cnt = 0;
    int                    issued_cnt = 0;
    int                    cycles = 0;
    integer                seed;
    logic [`TCB_ADR-1:0]   mem_adr [MEM_WORDS];

    tcb_lite_subsystem DUT (
        .clk    (clk),
        .arst_n (arst_n),
        .vld    (vld),
        .op     (op),
        .adr    (adr),
        .ben    (ben),
        .wdt    (wdt),
        .rdy    (rdy),
        .rdt    (rdt),
        .err    (err)
    );

    ////////////////////////////////////////////////////////////////////////
    // clock and timeout
    ////////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////

    // watches each transfer and sets up the response for the next cycle
    always @(posedge clk) begin : ref_model
        logic [`TCB_DAT-1:0] word;
        if (!arst_n) begin
            chk_pend <= 1'b0;
        end else if (vld && rdy) begin
            trn_cnt++;
            chk_pend <= 1'b1;
            chk_rdt  <= 1'b0;
            exp_rdt  <= '0;
            exp_err  <= 1'b0;
            exp_test <= test_name;
            if (adr[31:12] == 20'h0_0000) begin
                // memory region, enabled bytes merge over the old word
                if (op == tcb_lite_pkg::TCB_WRITE) begin
                    word = mem_model.exists(adr) ? mem_model[adr] : '0;
                    for (int b = 0; b < `TCB_BEN; b++) begin
                        if (ben[b]) begin
                            word[8*b +: 8] = wdt[8*b +: 8];
                        end
                    end
                    mem_model[adr] = word;
                end else begin
                    chk_rdt <= 1'b1;
                    exp_rdt <= mem_model[adr];
                end
            end else if (adr[31:4] == 28'h000_0100) begin
                // mailbox, bit 2 picks data or status
                if (adr[2] == 1'b0) begin
                    if (op == tcb_lite_pkg::TCB_WRITE) begin
                        mbx_model.push_back(wdt);
                    end else if (mbx_model.size() == 0) begin
                        exp_err <= 1'b1;
                    end else begin
                        chk_rdt <= 1'b1;
                        exp_rdt <= mbx_model.pop_front();
                    end
                end else if (op == tcb_lite_pkg::TCB_READ) begin
                    chk_rdt <= 1'b1;
                    exp_rdt <= `TCB_DAT'(mbx_model.size());
                end
            end else begin
                // unmapped, answered by the demux
                exp_err <= 1'b1;
            end
        end else begin
            chk_pend <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // response checks
    ////////////////////////////////////////////////////////////////////////

    a_err : assert property (
        @(posedge clk) disable iff (!arst_n)
        chk_pend |-> (err === exp_err)
    ) else begin
        $display("** Error [%s] err expected %0b actual %0b",
                 exp_test, $sampled(exp_err), $sampled(err));
        $display("STATUS: FAIL");
        $fatal(1, "err mismatch");
    end

    a_rdt : assert property (
        @(posedge clk) disable iff (!arst_n)
        (chk_pend && chk_rdt) |-> (rdt === exp_rdt)
    ) else begin
        $display("** Error [%s] rdt expected %h actual %h",
                 exp_test, $sampled(exp_rdt), $sampled(rdt));
        $display("STATUS: FAIL");
        $fatal(1, "rdt mismatch");
    end

    // full mailbox keeps a data write waiting
    a_stall : assert property (
        @(posedge clk) disable iff (!arst_n)
        (hold_stall && vld) |-> !rdy
    ) else begin
        $display("** Error [%s] rdy expected 0 actual %0b", test_name, $sampled(rdy));
        $display("STATUS: FAIL");
        $fatal(1, "write into full mailbox not stalled");
    end

    ////////////////////////////////////////////////////////////////////////
    // bus tasks
    ////////////////////////////////////////////////////////////////////////

    // drives one request and returns on the edge where it is taken
    // the next call drives on that same edge, so vld stays high
    task automatic transfer(input tcb_lite_pkg::tcb_op_t t_op, input logic [`TCB_ADR-1:0] t_adr,
                            input logic [`TCB_BEN-1:0] t_ben, input logic [`TCB_DAT-1:0] t_wdt);
        vld <= 1'b1;
        op  <= t_op;
        adr <= t_adr;
        ben <= t_ben;
        wdt <= t_wdt;
        do begin
            @(posedge clk);
        end while (!rdy);
        issued_cnt++;
    endtask

    task automatic write_word(input logic [`TCB_ADR-1:0] t_adr, input logic [`TCB_BEN-1:0] t_ben,
                              input logic [`TCB_DAT-1:0] t_wdt);
        transfer(tcb_lite_pkg::TCB_WRITE, t_adr, t_ben, t_wdt);
    endtask

    task automatic read_word(input logic [`TCB_ADR-1:0] t_adr);
        transfer(tcb_lite_pkg::TCB_READ, t_adr, '0, '0);
    endtask

    task automatic idle(input int n);
        vld <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    // holds a write that the full mailbox must refuse, then withdraws it
    // single manager, so the pop can only go out once the bus is free
    task automatic refused_write(input logic [`TCB_ADR-1:0] t_adr, input logic [`TCB_DAT-1:0] t_wdt,
                                 input int n);
        vld        <= 1'b1;
        op         <= tcb_lite_pkg::TCB_WRITE;
        adr        <= t_adr;
        ben        <= '1;
        wdt        <= t_wdt;
        hold_stall <= 1'b1;
        repeat (n) @(posedge clk);
        vld        <= 1'b0;
        hold_stall <= 1'b0;
        @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]         rnd;
        logic [`TCB_DAT-1:0] held;
        seed       = 32'hcd53_7c86;
        arst_n     = 1'b0;
        vld        = 1'b0;
        op         = tcb_lite_pkg::TCB_READ;
        adr        = '0;
        ben        = '0;
        wdt        = '0;
        hold_stall = 1'b0;
        test_name  = "reset";
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        // full word first, then random byte lanes on top
        test_name <= "memory";
        for (int i = 0; i < MEM_WORDS; i++) begin
            rnd = $random(seed);
            mem_adr[i] = 32'(i * 64) + {26'd0, rnd[3:0], 2'b00};
            write_word(mem_adr[i], 4'hf, $random(seed));
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            rnd = $random(seed);
            write_word(mem_adr[i], rnd[3:0], $random(seed));
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            read_word(mem_adr[i]);
        end
        idle(1);

        // 0x2000 aliases onto memory word 0 if it ever got through
        // word 0 gets a known value first
        test_name <= "unmapped";
        write_word(32'h0000_0000, 4'hf, 32'h0bad_f00d);
        read_word(UNMAPPED_ADR);
        write_word(UNMAPPED_ADR, 4'hf, 32'hdead_beef);
        write_word(UNMAPPED_MBX, 4'hf, 32'h1234_5678);
        read_word(mem_adr[0]);
        read_word(32'h0000_0000);
        idle(1);

        test_name <= "mailbox order";
        read_word(MBX_STAT_ADR);
        for (int i = 0; i < 3; i++) begin
            write_word(MBX_DATA_ADR, 4'hf, $random(seed));
            read_word(MBX_STAT_ADR);
        end
        // status write has no effect
        write_word(MBX_STAT_ADR, 4'hf, 32'hffff_ffff);
        for (int i = 0; i < 3; i++) begin
            read_word(MBX_DATA_ADR);
        end
        read_word(MBX_STAT_ADR);
        idle(1);

        test_name <= "back-pressure";
        for (int i = 0; i < `MBX_DEPTH; i++) begin
            write_word(MBX_DATA_ADR, 4'hf, $random(seed));
        end
        read_word(MBX_STAT_ADR);
        idle(1);
        held = $random(seed);
        refused_write(MBX_DATA_ADR, held, 4);
        read_word(MBX_DATA_ADR);
        // space again, the same write now goes through
        write_word(MBX_DATA_ADR, 4'hf, held);
        read_word(MBX_STAT_ADR);
        for (int i = 0; i < `MBX_DEPTH; i++) begin
            read_word(MBX_DATA_ADR);
        end
        idle(1);

        test_name <= "empty mailbox";
        read_word(MBX_DATA_ADR);
        read_word(MBX_STAT_ADR);
        read_word(MBX_DATA_ADR);
        read_word(MBX_STAT_ADR);
        idle(1);

        // vld stays high across the whole loop
        test_name <= "back-to-back";
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            read_word(mem_adr[i]);
            write_word(MBX_DATA_ADR, 4'hf, $random(seed));
            read_word(UNMAPPED_ADR);
            write_word(mem_adr[i], rnd[3:0], $random(seed));
            read_word(MBX_DATA_ADR);
            read_word(mem_adr[i]);
            write_word(UNMAPPED_ADR, 4'hf, $random(seed));
            read_word(MBX_STAT_ADR);
        end
        idle(3);

        if (trn_cnt == issued_cnt) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("transfer count mismatch: model saw %0d, stimulus issued %0d",
                     trn_cnt, issued_cnt);
            $display("STATUS: FAIL");
            $fatal(1, "transfer count mismatch");
        end
    end

endmodule : tcb_lite_subsystem_tb

`default_nettype wire

// ==== tcb_lite_subsystem.f ====
+incdir+common
common/tcb_lite_pkg.sv
interconnect/tcb_lite_lib_decoder.sv
interconnect/tcb_lite_lib_demultiplexer.sv
rtl/tcb_lite_lib_memory.sv
rtl/tcb_lite_lib_mailbox.sv
rtl/tcb_lite_subsystem.sv
testbench/tcb_lite_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the TCB-Lite subsystem testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f tcb_lite_subsystem.f \
    --top-module tcb_lite_subsystem_tb \
    -o tcb_lite_subsystem_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/tcb_lite_subsystem_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
